// ==== Bender.yml ====
package:
  name: rv_core_pipeline

sources:
  - logic/rv_pkg.sv
  - logic/rv_regfile.sv
  - logic/rv_decode.sv
  - logic/rv_execute.sv
  - logic/rv_result.sv
  - logic/rv_core_top.sv
  - target: simulation
    files:
      - sim/rv_tb_clock.sv
      - sim/rv_core_assert.sv
      - sim/rv_core_tb.sv

// ==== flist.f ====
logic/rv_pkg.sv
logic/rv_regfile.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_result.sv
logic/rv_core_top.sv
sim/rv_tb_clock.sv
sim/rv_core_assert.sv
sim/rv_core_tb.sv

// ==== logic/rv_core_top.sv ====
`default_nettype none

module rv_core_top #(
    parameter rv_pkg::addr_t RESET_PC    = '0,
    parameter int            NUM_CREDITS = 4
) (
    input  logic            itf,
    input  logic            rst_n,
    output rv_pkg::addr_t   imem_addr,
    input  rv_pkg::word_t   imem_rdata,
    output logic            commit_valid,
    output rv_pkg::commit_t commit,
    input  logic            credit_return,
    output logic            halted,
    output rv_pkg::stat_t   br_total,
    output rv_pkg::stat_t   br_mispredict,
    output rv_pkg::stat_t   jal_total
);
    import rv_pkg::*;

    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rs1_data;
    word_t    rs2_data;
    dec_exe_t dec_exe;
    exe_res_t exe_res;
    logic     redirect_valid;
    addr_t    redirect_pc;
    logic     stall;
    // shared by the register file and the forward path
    logic     wb_en;
    reg_idx_t wb_rd;
    word_t    wb_data;

    rv_decode #(
        .RESET_PC (RESET_PC)
    ) u_rv_decode (
        .itf            (itf),
        .rst_n          (rst_n),
        .imem_rdata     (imem_rdata),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .stall          (stall),
        .halted         (halted),
        .imem_addr      (imem_addr),
        .rs1            (rs1),
        .rs2            (rs2),
        .dec_exe        (dec_exe)
    );

    rv_regfile u_rv_regfile (
        .itf      (itf),
        .rst_n    (rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_execute u_rv_execute (
        .itf            (itf),
        .rst_n          (rst_n),
        .dec_exe        (dec_exe),
        .wb_en          (wb_en),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data),
        .stall          (stall),
        .exe_res        (exe_res),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    rv_result #(
        .NUM_CREDITS (NUM_CREDITS)
    ) u_rv_result (
        .itf           (itf),
        .rst_n         (rst_n),
        .exe_res       (exe_res),
        .credit_return (credit_return),
        .wb_en         (wb_en),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .stall         (stall),
        .commit_valid  (commit_valid),
        .commit        (commit),
        .halted        (halted),
        .br_total      (br_total),
        .br_mispredict (br_mispredict),
        .jal_total     (jal_total)
    );

endmodule

`default_nettype wire

// ==== logic/rv_decode.sv ====
`default_nettype none

module rv_decode #(
    parameter rv_pkg::addr_t RESET_PC = '0
) (
    input  logic             itf,
    input  logic             rst_n,
    input  rv_pkg::word_t    imem_rdata,
    input  rv_pkg::word_t    rs1_data,
    input  rv_pkg::word_t    rs2_data,
    input  logic             redirect_valid,
    input  rv_pkg::addr_t    redirect_pc,
    input  logic             stall,
    input  logic             halted,
    output rv_pkg::addr_t    imem_addr,
    output rv_pkg::reg_idx_t rs1,
    output rv_pkg::reg_idx_t rs2,
    output rv_pkg::dec_exe_t dec_exe
);
    import rv_pkg::*;

    addr_t      pc_q;
    addr_t      pc_next;
    dec_exe_t   dec_d;
    dec_exe_t   dec_q;
    logic [6:0] opcode;
    logic [2:0] funct3;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_b;
    word_t      imm_j;
    logic       take_jump;

    // funct3 to ALU op, shared by register and immediate forms
    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic sub);
        alu_op_e op;
        case (f3)
            3'b000:  op = sub ? ALU_SUB : ALU_ADD;
            3'b100:  op = ALU_XOR;
            3'b110:  op = ALU_OR;
            3'b111:  op = ALU_AND;
            default: op = ALU_ADD;
        endcase
        return op;
    endfunction

    // instruction fields
    assign opcode = imem_rdata[6:0];
    assign funct3 = imem_rdata[14:12];
    assign rs1    = imem_rdata[19:15];
    assign rs2    = imem_rdata[24:20];

    // sign-extended immediates
    assign imm_i = {{20{imem_rdata[31]}}, imem_rdata[31:20]};
    assign imm_u = {imem_rdata[31:12], 12'b0};
    assign imm_b = {{19{imem_rdata[31]}}, imem_rdata[31], imem_rdata[7],
                    imem_rdata[30:25], imem_rdata[11:8], 1'b0};
    assign imm_j = {{11{imem_rdata[31]}}, imem_rdata[31], imem_rdata[19:12],
                    imem_rdata[20], imem_rdata[30:21], 1'b0};

    always_comb begin
        dec_d         = '0;
        // nothing new enters once halted
        dec_d.valid   = !halted;
        dec_d.pc      = pc_q;
        dec_d.insn    = imem_rdata;
        dec_d.rs1     = rs1;
        dec_d.rs2     = rs2;
        dec_d.rs1_val = rs1_data;
        dec_d.rs2_val = rs2_data;
        dec_d.rd      = imem_rdata[11:7];
        dec_d.alu_op  = ALU_ADD;
        case (opcode)
            OPC_OPIMM: begin
                dec_d.imm     = imm_i;
                dec_d.use_imm = 1'b1;
                dec_d.alu_op  = alu_decode(funct3, 1'b0);
                dec_d.we      = 1'b1;
            end
            OPC_OP: begin
                // bit 30 selects sub
                dec_d.alu_op = alu_decode(funct3, imem_rdata[30]);
                dec_d.we     = 1'b1;
            end
            OPC_LUI: begin
                dec_d.imm     = imm_u;
                dec_d.use_imm = 1'b1;
                dec_d.alu_op  = ALU_PASS_B;
                dec_d.we      = 1'b1;
            end
            OPC_BRANCH: begin
                dec_d.imm        = imm_b;
                dec_d.is_branch  = 1'b1;
                dec_d.is_bne     = funct3[0];
                // BTFNT, backward offset means taken
                dec_d.pred_taken = imm_b[31];
            end
            OPC_JAL: begin
                dec_d.imm    = imm_j;
                dec_d.is_jal = 1'b1;
                dec_d.we     = 1'b1;
            end
            default: begin
                // unsupported words retire as no-ops
                dec_d.we = 1'b0;
            end
        endcase
        // writes to x0 are dropped here
        dec_d.we = dec_d.we && (dec_d.rd != '0);
    end

    // jal and predicted-taken branches steer fetch right away
    assign take_jump = dec_d.valid && (dec_d.is_jal || dec_d.pred_taken);
    assign pc_next   = take_jump ? pc_q + dec_d.imm : pc_q + 32'd4;

    // redirect wins over everything, it is never raised during a stall
    always_ff @(posedge itf) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else if (redirect_valid) begin
            pc_q <= redirect_pc;
        end else if (!stall && !halted) begin
            pc_q <= pc_next;
        end
    end

    // wrong-path word becomes a bubble
    always_ff @(posedge itf) begin
        if (!rst_n) begin
            dec_q.valid <= 1'b0;
        end else if (redirect_valid) begin
            dec_q.valid <= 1'b0;
        end else if (!stall) begin
            dec_q <= dec_d;
        end
    end

    assign imem_addr = pc_q;
    assign dec_exe   = dec_q;

endmodule

`default_nettype wire

// ==== logic/rv_execute.sv ====
`default_nettype none

module rv_execute (
    input  logic             itf,
    input  logic             rst_n,
    input  rv_pkg::dec_exe_t dec_exe,
    input  logic             wb_en,
    input  rv_pkg::reg_idx_t wb_rd,
    input  rv_pkg::word_t    wb_data,
    input  logic             stall,
    output rv_pkg::exe_res_t exe_res,
    output logic             redirect_valid,
    output rv_pkg::addr_t    redirect_pc
);
    import rv_pkg::*;

    word_t    op_a;
    word_t    op_b;
    word_t    alu_b;
    word_t    alu_out;
    addr_t    seq_pc;
    addr_t    target;
    addr_t    resolved_pc;
    logic     equal;
    logic     taken;
    logic     mispredict;
    exe_res_t res_d;
    exe_res_t res_q;

    // take the committing result when it targets this source
    function automatic word_t fwd(input reg_idx_t idx, input word_t val);
        word_t sel;
        sel = val;
        if (wb_en && wb_rd == idx && idx != '0) begin
            sel = wb_data;
        end
        return sel;
    endfunction

    assign op_a  = fwd(dec_exe.rs1, dec_exe.rs1_val);
    assign op_b  = fwd(dec_exe.rs2, dec_exe.rs2_val);
    assign alu_b = dec_exe.use_imm ? dec_exe.imm : op_b;

    always_comb begin
        case (dec_exe.alu_op)
            ALU_ADD:    alu_out = op_a + alu_b;
            ALU_SUB:    alu_out = op_a - alu_b;
            ALU_AND:    alu_out = op_a & alu_b;
            ALU_OR:     alu_out = op_a | alu_b;
            ALU_XOR:    alu_out = op_a ^ alu_b;
            ALU_PASS_B: alu_out = alu_b;
            default:    alu_out = op_a + alu_b;
        endcase
    end

    // branch resolution
    assign seq_pc      = dec_exe.pc + 32'd4;
    assign target      = dec_exe.pc + dec_exe.imm;
    assign equal       = (op_a == op_b);
    assign taken       = dec_exe.is_jal || (dec_exe.is_branch && (equal ^ dec_exe.is_bne));
    assign resolved_pc = taken ? target : seq_pc;
    // jal is never wrong, decode already followed it
    assign mispredict  = dec_exe.is_branch && (taken != dec_exe.pred_taken);

    always_comb begin
        res_d            = '0;
        res_d.valid      = dec_exe.valid;
        res_d.pc         = dec_exe.pc;
        res_d.insn       = dec_exe.insn;
        res_d.rd         = dec_exe.rd;
        res_d.we         = dec_exe.we;
        // link value for jal
        res_d.result     = dec_exe.is_jal ? seq_pc : alu_out;
        res_d.is_branch  = dec_exe.is_branch;
        res_d.is_jal     = dec_exe.is_jal;
        res_d.taken      = taken;
        res_d.mispredict = mispredict;
        // self-targeted control transfer ends the program
        res_d.halt       = (dec_exe.is_branch || dec_exe.is_jal) && (resolved_pc == dec_exe.pc);
    end

    // held back while stalled so the branch is not lost from the decode register
    assign redirect_valid = dec_exe.valid && mispredict && !stall;
    assign redirect_pc    = resolved_pc;

    always_ff @(posedge itf) begin
        if (!rst_n) begin
            res_q.valid <= 1'b0;
        end else if (!stall) begin
            res_q <= res_d;
        end
    end

    assign exe_res = res_q;

endmodule

`default_nettype wire

// ==== logic/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // meaningful widths
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] order_t;
    typedef logic [31:0] stat_t;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // pass-b carries the LUI immediate straight through
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    // decode to execute
    typedef struct packed {
        logic     valid;
        addr_t    pc;
        word_t    insn;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    rs1_val;
        word_t    rs2_val;
        word_t    imm;
        alu_op_e  alu_op;
        logic     use_imm;
        reg_idx_t rd;
        logic     we;
        logic     is_branch;
        logic     is_bne;
        logic     is_jal;
        logic     pred_taken;
    } dec_exe_t;

    // execute to result
    typedef struct packed {
        logic     valid;
        addr_t    pc;
        word_t    insn;
        reg_idx_t rd;
        logic     we;
        word_t    result;
        logic     is_branch;
        logic     is_jal;
        logic     taken;
        logic     mispredict;
        logic     halt;
    } exe_res_t;

    // one record per retired instruction
    typedef struct packed {
        order_t   order;
        addr_t    pc;
        word_t    insn;
        reg_idx_t rd;
        word_t    rd_wdata;
        logic     we;
        logic     halt;
    } commit_t;

endpackage

`default_nettype wire

// ==== logic/rv_regfile.sv ====
`default_nettype none

module rv_regfile (
    input  logic             itf,
    input  logic             rst_n,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  logic             wb_en,
    input  rv_pkg::reg_idx_t wb_rd,
    input  rv_pkg::word_t    wb_data,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data
);
    import rv_pkg::*;

    // x0 has no storage
    word_t regs [31:1];

    // zero for x0, new value when written this cycle
    function automatic word_t read_port(input reg_idx_t idx);
        word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (wb_en && wb_rd == idx) begin
            val = wb_data;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    // writes are ignored while in reset
    always_ff @(posedge itf) begin
        if (rst_n && wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    assign rs1_data = read_port(rs1);
    assign rs2_data = read_port(rs2);

endmodule

`default_nettype wire

// ==== logic/rv_result.sv ====
`default_nettype none

module rv_result #(
    parameter int NUM_CREDITS = 4
) (
    input  logic             itf,
    input  logic             rst_n,
    input  rv_pkg::exe_res_t exe_res,
    input  logic             credit_return,
    output logic             wb_en,
    output rv_pkg::reg_idx_t wb_rd,
    output rv_pkg::word_t    wb_data,
    output logic             stall,
    output logic             commit_valid,
    output rv_pkg::commit_t  commit,
    output logic             halted,
    output rv_pkg::stat_t    br_total,
    output rv_pkg::stat_t    br_mispredict,
    output rv_pkg::stat_t    jal_total
);
    import rv_pkg::*;

    localparam int CREDIT_W = $clog2(NUM_CREDITS + 1);

    logic [CREDIT_W-1:0] credit_cnt;
    order_t              order_cnt;
    logic                halted_q;
    logic                fire;
    stat_t               br_cnt;
    stat_t               misp_cnt;
    stat_t               jal_cnt;

    // commit needs a credit; after halt records just drain
    assign fire  = exe_res.valid && (credit_cnt != '0) && !halted_q;
    assign stall = exe_res.valid && (credit_cnt == '0);

    // regfile write and forward path
    assign wb_en   = fire && exe_res.we;
    assign wb_rd   = exe_res.rd;
    assign wb_data = exe_res.result;

    always_comb begin
        commit.order    = order_cnt;
        commit.pc       = exe_res.pc;
        commit.insn     = exe_res.insn;
        // rd and data read zero when nothing is written
        commit.rd       = exe_res.we ? exe_res.rd : '0;
        commit.rd_wdata = exe_res.we ? exe_res.result : '0;
        commit.we       = exe_res.we;
        commit.halt     = exe_res.halt;
    end

    // one spent per commit, one back per return
    always_ff @(posedge itf) begin
        if (!rst_n) begin
            credit_cnt <= CREDIT_W'(NUM_CREDITS);
        end else begin
            credit_cnt <= credit_cnt - CREDIT_W'(fire) + CREDIT_W'(credit_return);
        end
    end

    // order, halt latch and statistics all count at commit
    always_ff @(posedge itf) begin
        if (!rst_n) begin
            order_cnt <= '0;
            halted_q  <= 1'b0;
            br_cnt    <= '0;
            misp_cnt  <= '0;
            jal_cnt   <= '0;
        end else if (fire) begin
            order_cnt <= order_cnt + 32'd1;
            halted_q  <= exe_res.halt;
            br_cnt    <= br_cnt + stat_t'(exe_res.is_branch);
            misp_cnt  <= misp_cnt + stat_t'(exe_res.mispredict);
            jal_cnt   <= jal_cnt + stat_t'(exe_res.is_jal);
        end
    end

    assign commit_valid  = fire;
    assign halted        = halted_q;
    assign br_total      = br_cnt;
    assign br_mispredict = misp_cnt;
    assign jal_total     = jal_cnt;

endmodule

`default_nettype wire

// ==== sim/rv_core_assert.sv ====
`default_nettype none

module rv_core_assert #(
    parameter int NUM_CREDITS = 4,
    parameter int CREDIT_W    = 3
) (
    input  logic                itf,
    input  logic                rst_n,
    input  logic [CREDIT_W-1:0] credit_cnt,
    input  logic                commit_valid,
    input  rv_pkg::commit_t     commit,
    input  logic                halted
);
    import rv_pkg::*;

    // failures seen so far, polled by the testbench
    int     fail_cnt = 0;
    // history of the monitor stream
    order_t commits_seen;
    logic   halt_seen;

    always_ff @(posedge itf) begin
        if (!rst_n) begin
            commits_seen <= '0;
            halt_seen    <= 1'b0;
        end else if (commit_valid) begin
            commits_seen <= commits_seen + 32'd1;
            halt_seen    <= halt_seen || commit.halt;
        end
    end

    // an underflow would wrap above the limit
    credit_range: assert property (@(posedge itf) disable iff (!rst_n)
        credit_cnt <= CREDIT_W'(NUM_CREDITS))
    else begin
        $error("credit count outside 0 to %0d", NUM_CREDITS);
        fail_cnt++;
    end

    // order numbers the commits from zero without gaps
    order_count: assert property (@(posedge itf) disable iff (!rst_n)
        commit_valid |-> commit.order == commits_seen)
    else begin
        $error("commit order does not match the number of earlier commits");
        fail_cnt++;
    end

    // halted follows the halt commit and the stream stays quiet
    halt_quiet: assert property (@(posedge itf) disable iff (!rst_n)
        halt_seen |-> halted && !commit_valid)
    else begin
        $error("halt commit not followed by halted and a quiet commit stream");
        fail_cnt++;
    end

endmodule

bind rv_result rv_core_assert #(
    .NUM_CREDITS (NUM_CREDITS),
    .CREDIT_W    (CREDIT_W)
) u_rv_core_assert (
    .itf          (itf),
    .rst_n        (rst_n),
    .credit_cnt   (credit_cnt),
    .commit_valid (commit_valid),
    .commit       (commit),
    .halted       (halted)
);

`default_nettype wire

// ==== sim/rv_core_tb.sv ====
`default_nettype none

module rv_core_tb;
    import rv_pkg::*;

    localparam int    NUM_CREDITS = 4;
    localparam addr_t RESET_PC    = 32'h0;
    localparam int    NUM_ROWS    = 29;
    localparam int    TIMEOUT     = NUM_ROWS * 12 + 100;
    localparam int    IMEM_WORDS  = 64;
    localparam word_t NOP         = 32'h0000_0013;

    logic    itf;
    logic    rst_n;
    addr_t   imem_addr;
    word_t   imem_rdata;
    logic    commit_valid;
    commit_t commit;
    logic    credit_return;
    logic    halted;
    stat_t   br_total;
    stat_t   br_mispredict;
    stat_t   jal_total;

    // expected commit stream, one row per retired instruction
    string    row_name [NUM_ROWS];
    addr_t    row_pc   [NUM_ROWS];
    word_t    row_insn [NUM_ROWS];
    reg_idx_t row_rd   [NUM_ROWS];
    word_t    row_data [NUM_ROWS];
    int       row_cnt;

    word_t       imem [IMEM_WORDS];
    logic [31:0] lcg_state;
    int          cycle_cnt;
    int          credits_avail;
    // cycle at which each taken credit goes back
    int          return_due [$];

    rv_tb_clock u_rv_tb_clock (
        .itf   (itf),
        .rst_n (rst_n)
    );

    rv_core_top #(
        .RESET_PC    (RESET_PC),
        .NUM_CREDITS (NUM_CREDITS)
    ) u_rv_core_top (
        .itf           (itf),
        .rst_n         (rst_n),
        .imem_addr     (imem_addr),
        .imem_rdata    (imem_rdata),
        .commit_valid  (commit_valid),
        .commit        (commit),
        .credit_return (credit_return),
        .halted        (halted),
        .br_total      (br_total),
        .br_mispredict (br_mispredict),
        .jal_total     (jal_total)
    );

    // RV32I encoders
    function automatic word_t op_imm(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], OPC_OPIMM};
    endfunction

    function automatic word_t op_reg(input int f7, input int f3, input int rd,
                                     input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
    endfunction

    function automatic word_t lui_word(input int rd, input int imm);
        return {imm[19:0], rd[4:0], OPC_LUI};
    endfunction

    function automatic word_t branch_word(input int f3, input int rs1, input int rs2,
                                          input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                OPC_BRANCH};
    endfunction

    function automatic word_t jal_word(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
    endfunction

    // 0 to 3 cycles of credit delay
    function automatic int next_delay();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[17:16]);
    endfunction

    // anything outside the array reads as NOP
    function automatic word_t fetch_word(input addr_t addr);
        word_t w;
        w = NOP;
        if (addr[31:8] == '0) begin
            w = imem[addr[7:2]];
        end
        return w;
    endfunction

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_word(input string name, input string field,
                              input word_t exp, input word_t act);
        assert (act === exp) else begin
            report_failure($sformatf("MISMATCH %s %s expected %h actual %h",
                                     name, field, exp, act));
        end
    endtask

    task automatic add_row(input string name, input addr_t pc, input word_t insn,
                           input int rd, input word_t data);
        row_name[row_cnt] = name;
        row_pc[row_cnt]   = pc;
        row_insn[row_cnt] = insn;
        row_rd[row_cnt]   = rd[4:0];
        row_data[row_cnt] = data;
        row_cnt++;
    endtask

    task automatic build_program();
        int i;
        // arithmetic chain, each step leans on the one before
        add_row("addi_base", 32'h00, op_imm(1, 0, 'h5a), 1, 32'h0000_005a);
        add_row("addi_fwd", 32'h04, op_imm(2, 1, 'h33), 2, 32'h0000_008d);
        add_row("add_fwd", 32'h08, op_reg(0, 0, 3, 1, 2), 3, 32'h0000_00e7);
        add_row("sub", 32'h0c, op_reg(32, 0, 4, 2, 3), 4, 32'hffff_ffa6);
        add_row("and", 32'h10, op_reg(0, 7, 5, 3, 4), 5, 32'h0000_00a6);
        add_row("or", 32'h14, op_reg(0, 6, 6, 1, 5), 6, 32'h0000_00fe);
        add_row("xor", 32'h18, op_reg(0, 4, 7, 6, 4), 7, 32'hffff_ff58);
        add_row("lui", 32'h1c, lui_word(8, 'h12345), 8, 32'h1234_5000);
        add_row("addi_neg", 32'h20, op_imm(8, 8, -1), 8, 32'h1234_4fff);
        // backward bne loop, four passes
        add_row("loop_count", 32'h24, op_imm(9, 0, 4), 9, 32'h4);
        add_row("loop_acc", 32'h28, op_imm(10, 0, 0), 10, 32'h0);
        for (i = 0; i < 4; i++) begin
            add_row("loop_add", 32'h2c, op_reg(0, 0, 10, 10, 1), 10, 32'h5a * (i + 1));
            add_row("loop_dec", 32'h30, op_imm(9, 9, -1), 9, 3 - i);
            add_row("loop_bne", 32'h34, branch_word(1, 9, 0, -8), 0, 32'h0);
        end
        // forward beq, taken and then not taken
        add_row("beq_taken", 32'h38, branch_word(0, 9, 0, 8), 0, 32'h0);
        add_row("beq_not_taken", 32'h40, branch_word(0, 1, 0, 8), 0, 32'h0);
        add_row("addi_after_beq", 32'h44, op_imm(11, 0, 'h11), 11, 32'h11);
        add_row("jal_link", 32'h48, jal_word(12, 12), 12, 32'h4c);
        add_row("add_link", 32'h54, op_reg(0, 0, 14, 12, 11), 14, 32'h5d);
        add_row("jal_halt", 32'h58, jal_word(0, 0), 0, 32'h0);
    endtask

    task automatic load_imem();
        int i;
        for (i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = NOP;
        end
        for (i = 0; i < NUM_ROWS; i++) begin
            imem[row_pc[i][7:2]] = row_insn[i];
        end
        // skipped words that would corrupt x11 to x13 if they ever retired
        imem[6'h0f] = op_imm(11, 0, 'h7ff);
        imem[6'h13] = op_imm(12, 0, 'h123);
        imem[6'h14] = op_imm(13, 0, 1);
    endtask

    // BTFNT prediction against the path the table actually takes
    task automatic count_expected(output int br, output int misp, output int jal);
        int   i;
        logic pred;
        logic taken;
        br   = 0;
        misp = 0;
        jal  = 0;
        for (i = 0; i < NUM_ROWS; i++) begin
            if (row_insn[i][6:0] == OPC_BRANCH) begin
                br++;
                pred  = row_insn[i][31];
                taken = 1'b0;
                if (i + 1 < NUM_ROWS) begin
                    taken = (row_pc[i + 1] != row_pc[i] + 32'd4);
                end
                if (pred != taken) begin
                    misp++;
                end
            end else if (row_insn[i][6:0] == OPC_JAL) begin
                jal++;
            end
        end
    endtask

    task automatic wait_commit();
        do begin
            @(negedge itf);
        end while (!commit_valid);
    endtask

    // timeout and bound assertion watch
    always @(posedge itf) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT) begin
            report_failure($sformatf("timeout after %0d cycles before the run ended",
                                     TIMEOUT));
        end else if (u_rv_core_top.u_rv_result.u_rv_core_assert.fail_cnt != 0) begin
            report_failure("a bound assertion on the result stage reported an error");
        end
    end

    // memory answer and credit return, both on the falling edge
    always @(negedge itf) begin
        if (rst_n) begin
            if (commit_valid) begin
                assert (credits_avail > 0) else begin
                    report_failure("commit_valid seen with no credit left in the testbench");
                end
                credits_avail--;
                return_due.push_back(cycle_cnt + next_delay());
            end
            if (return_due.size() > 0 && return_due[0] <= cycle_cnt) begin
                void'(return_due.pop_front());
                credit_return = 1'b1;
                credits_avail++;
            end else begin
                credit_return = 1'b0;
            end
        end
        imem_rdata = fetch_word(imem_addr);
    end

    initial begin
        int idx;
        int exp_br;
        int exp_misp;
        int exp_jal;
        imem_rdata    = NOP;
        credit_return = 1'b0;
        credits_avail = NUM_CREDITS;
        cycle_cnt     = 0;
        lcg_state     = 32'h4f9a;
        row_cnt       = 0;
        build_program();
        assert (row_cnt == NUM_ROWS) else begin
            report_failure("program table length differs from NUM_ROWS");
        end
        load_imem();
        count_expected(exp_br, exp_misp, exp_jal);

        @(posedge rst_n);
        check_word("reset", "pc", RESET_PC, imem_addr);
        check_word("reset", "commit_valid", 32'h0, word_t'(commit_valid));
        check_word("reset", "halted", 32'h0, word_t'(halted));
        check_word("reset", "br_total", 32'h0, br_total);
        check_word("reset", "br_mispredict", 32'h0, br_mispredict);
        check_word("reset", "jal_total", 32'h0, jal_total);

        for (idx = 0; idx < NUM_ROWS; idx++) begin
            wait_commit();
            check_word(row_name[idx], "order", word_t'(idx), commit.order);
            check_word(row_name[idx], "pc", row_pc[idx], commit.pc);
            check_word(row_name[idx], "insn", row_insn[idx], commit.insn);
            check_word(row_name[idx], "rd", word_t'(row_rd[idx]), word_t'(commit.rd));
            check_word(row_name[idx], "rd_wdata", row_data[idx], commit.rd_wdata);
            // only a real destination register is written
            check_word(row_name[idx], "we", word_t'(row_rd[idx] != '0),
                       word_t'(commit.we));
            check_word(row_name[idx], "halt", word_t'(idx == NUM_ROWS - 1),
                       word_t'(commit.halt));
        end

        // halted follows the halt commit by one cycle
        @(negedge itf);
        check_word("halt", "halted", 32'h1, word_t'(halted));
        check_word("stats", "br_total", word_t'(exp_br), br_total);
        check_word("stats", "br_mispredict", word_t'(exp_misp), br_mispredict);
        check_word("stats", "jal_total", word_t'(exp_jal), jal_total);

        repeat (20) begin
            @(negedge itf);
            assert (!commit_valid) else begin
                report_failure("a commit appeared after the core halted");
            end
        end

        if (u_rv_core_top.u_rv_result.u_rv_core_assert.fail_cnt == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            report_failure("a bound assertion on the result stage reported an error");
        end
    end

endmodule

`default_nettype wire

// ==== sim/rv_tb_clock.sv ====
`default_nettype none

module rv_tb_clock #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 16
) (
    output logic itf,
    output logic rst_n
);

    initial begin
        itf = 1'b0;
        forever #HALF_PERIOD itf = ~itf;
    end

    // reset released on a falling edge, like every other input
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge itf);
        @(negedge itf);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire
